//--- frontend_settings.svh
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

// Address and fetch geometry
`define FE_ADDR_WIDTH 32
`define FE_FETCH_WIDTH 4

// Queue and predictor sizes
`define FE_FTQ_DEPTH 8
`define FE_BTB_ENTRIES 16
`define FE_PHT_ENTRIES 64

// Free places in the instruction buffer after reset
`define FE_IB_CREDITS 4

`define FE_RESET_PC 32'h1C00_0000

`endif

//--- frontend_pkg.sv
`include "frontend_settings.svh"
`default_nettype none

package frontend_pkg;

    typedef logic [`FE_ADDR_WIDTH-1:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(`FE_FETCH_WIDTH)-1:0] slot_idx_t;
    // Holds 1 up to the full fetch width
    typedef logic [$clog2(`FE_FETCH_WIDTH+1)-1:0] blk_len_t;
    typedef logic [1:0] pht_ctr_t;

    typedef struct packed {
        addr_t    start_pc;
        blk_len_t length;
        logic     taken;
        addr_t    target;
    } fetch_block_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
        logic  taken;
        addr_t target;
    } branch_update_t;

    typedef struct packed {
        logic      hit;
        slot_idx_t slot;
        addr_t     target;
    } btb_lookup_t;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } redirect_t;

    typedef struct packed {
        logic                           valid;
        logic [`FE_FETCH_WIDTH*32-1:0] line;
    } icache_rsp_t;

    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
    } instr_slot_t;

    typedef struct packed {
        logic                                valid;
        instr_slot_t [`FE_FETCH_WIDTH-1:0] slots;
    } instr_bundle_t;

endpackage

`default_nettype wire

//--- btb.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module btb (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`FE_ADDR_WIDTH-1:0]    lookup_pc_i,
    output frontend_pkg::btb_lookup_t    lookup_o,
    input  frontend_pkg::branch_update_t update_i
);
    import frontend_pkg::*;

    localparam int SLOT_W   = $clog2(`FE_FETCH_WIDTH);
    localparam int LINE_LSB = 2 + SLOT_W;
    localparam int IDX_W    = $clog2(`FE_BTB_ENTRIES);
    localparam int TAG_W    = `FE_ADDR_WIDTH - LINE_LSB - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        slot_idx_t        slot;
        addr_t            target;
    } btb_entry_t;

    btb_entry_t                 entries [`FE_BTB_ENTRIES];
    logic [`FE_BTB_ENTRIES-1:0] valid_q;
    btb_entry_t                 rd_entry;
    logic [IDX_W-1:0]           rd_idx;
    logic [TAG_W-1:0]           rd_tag;
    logic [IDX_W-1:0]           wr_idx;
    logic                       wr_en;

    // One entry per line address
    assign rd_idx   = lookup_pc_i[LINE_LSB +: IDX_W];
    assign rd_tag   = lookup_pc_i[LINE_LSB + IDX_W +: TAG_W];
    assign rd_entry = entries[rd_idx];

    assign lookup_o.hit    = valid_q[rd_idx] && (rd_entry.tag == rd_tag);
    assign lookup_o.slot   = rd_entry.slot;
    assign lookup_o.target = rd_entry.target;

    // Not-taken outcomes leave the entry alone
    assign wr_en  = update_i.valid && update_i.taken;
    assign wr_idx = update_i.pc[LINE_LSB +: IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_idx].tag    <= update_i.pc[LINE_LSB + IDX_W +: TAG_W];
            entries[wr_idx].slot   <= slot_idx_t'(update_i.pc[2 +: SLOT_W]);
            entries[wr_idx].target <= update_i.target;
        end
    end

endmodule

`default_nettype wire

//--- bimodal_pht.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module bimodal_pht (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`FE_ADDR_WIDTH-1:0]    lookup_pc_i,
    output logic                         taken_o,
    input  frontend_pkg::branch_update_t update_i
);
    import frontend_pkg::*;

    localparam int       IDX_W    = $clog2(`FE_PHT_ENTRIES);
    // Weakly not taken
    localparam pht_ctr_t CTR_INIT = 2'd1;

    pht_ctr_t         ctr_q [`FE_PHT_ENTRIES];
    pht_ctr_t         wr_ctr;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // Indexed by word address of the branch
    assign rd_idx  = lookup_pc_i[2 +: IDX_W];
    assign taken_o = ctr_q[rd_idx][1];
    assign wr_idx  = update_i.pc[2 +: IDX_W];

    // Saturating step toward the outcome
    always_comb begin
        wr_ctr = ctr_q[wr_idx];
        if (update_i.taken) begin
            if (wr_ctr != 2'd3) begin
                wr_ctr = wr_ctr + 2'd1;
            end
        end else if (wr_ctr != 2'd0) begin
            wr_ctr = wr_ctr - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FE_PHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (update_i.valid) begin
            ctr_q[wr_idx] <= wr_ctr;
        end
    end

endmodule

`default_nettype wire

//--- bpu.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module bpu (
    input  logic                         clk,
    input  logic                         rst_n,
    input  frontend_pkg::redirect_t      redirect_i,
    input  frontend_pkg::branch_update_t update_i,
    input  logic                         ftq_full_i,
    output logic                         push_o,
    output frontend_pkg::fetch_block_t   block_o
);
    import frontend_pkg::*;

    localparam int SLOT_W   = $clog2(`FE_FETCH_WIDTH);
    localparam int LINE_LSB = 2 + SLOT_W;

    addr_t       pc_q;
    addr_t       pc_d;
    addr_t       next_line_pc;
    addr_t       pht_pc;
    addr_t       pred_pc;
    slot_idx_t   pc_ofs;
    btb_lookup_t btb_res;
    logic        pht_taken;
    logic        pred_taken;
    blk_len_t    blk_len;

    btb u_btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc_i(pc_q),
        .lookup_o   (btb_res),
        .update_i   (update_i)
    );

    // Direction is looked up at the branch slot the btb reports
    assign pht_pc = {pc_q[`FE_ADDR_WIDTH-1:LINE_LSB], btb_res.slot, 2'b00};

    bimodal_pht u_pht (
        .clk        (clk),
        .rst_n      (rst_n),
        .lookup_pc_i(pht_pc),
        .taken_o    (pht_taken),
        .update_i   (update_i)
    );

    assign pc_ofs       = pc_q[2 +: SLOT_W];
    assign next_line_pc = {pc_q[`FE_ADDR_WIDTH-1:LINE_LSB] + 1'b1, {LINE_LSB{1'b0}}};

    // A branch before the entry point of the block is ignored
    assign pred_taken = btb_res.hit && (btb_res.slot >= pc_ofs) && pht_taken;

    always_comb begin
        if (pred_taken) begin
            blk_len = blk_len_t'(btb_res.slot) - blk_len_t'(pc_ofs) + blk_len_t'(1);
            pred_pc = btb_res.target;
        end else begin
            blk_len = blk_len_t'(`FE_FETCH_WIDTH) - blk_len_t'(pc_ofs);
            pred_pc = next_line_pc;
        end
    end

    assign block_o.start_pc = pc_q;
    assign block_o.length   = blk_len;
    assign block_o.taken    = pred_taken;
    assign block_o.target   = pred_pc;

    assign push_o = !ftq_full_i && !redirect_i.valid;

    // Redirect wins over a hold on full
    always_comb begin
        if (redirect_i.valid) begin
            pc_d = redirect_i.pc;
        end else if (ftq_full_i) begin
            pc_d = pc_q;
        end else begin
            pc_d = pred_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

endmodule

`default_nettype wire

//--- ftq.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module ftq (
    input  logic                       clk,
    input  logic                       rst_n,
    input  frontend_pkg::redirect_t    redirect_i,
    input  logic                       push_i,
    input  frontend_pkg::fetch_block_t block_i,
    output logic                       full_o,
    output logic                       head_valid_o,
    output frontend_pkg::fetch_block_t head_o,
    input  logic                       accept_i
);
    import frontend_pkg::*;

    localparam int PTR_W = $clog2(`FE_FTQ_DEPTH);
    localparam int CNT_W = $clog2(`FE_FTQ_DEPTH + 1);

    fetch_block_t     mem [`FE_FTQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o       = (count_q == CNT_W'(`FE_FTQ_DEPTH));
    assign head_valid_o = (count_q != '0);
    assign head_o       = mem[rd_ptr_q];

    assign do_push = push_i && !full_o;
    assign do_pop  = head_valid_o && accept_i;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (redirect_i.valid) begin
            // Whole queue is dropped
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= block_i;
        end
    end

endmodule

`default_nettype wire

//--- ifu.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module ifu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  frontend_pkg::redirect_t     redirect_i,
    input  logic                        head_valid_i,
    input  frontend_pkg::fetch_block_t  head_i,
    output logic                        accept_o,
    output logic                        icache_req_o,
    output logic [`FE_ADDR_WIDTH-1:0]   icache_addr_o,
    input  frontend_pkg::icache_rsp_t   icache_rsp_i,
    input  logic                        credit_return_i,
    output frontend_pkg::instr_bundle_t bundle_o
);
    import frontend_pkg::*;

    localparam int SLOT_W   = $clog2(`FE_FETCH_WIDTH);
    localparam int LINE_LSB = 2 + SLOT_W;
    localparam int CRD_W    = $clog2(`FE_IB_CREDITS + 1);

    logic [CRD_W-1:0]                  credit_q;
    logic                              epoch_q;
    logic                              cur_epoch;
    logic                              infl_valid_q;
    logic                              infl_epoch_q;
    fetch_block_t                      infl_blk_q;
    slot_idx_t                         infl_ofs;
    blk_len_t                          infl_end;
    logic                              deliver;
    logic                              refund;
    instr_slot_t [`FE_FETCH_WIDTH-1:0] slots_d;
    instr_slot_t [`FE_FETCH_WIDTH-1:0] slots_q;
    logic                              bundle_valid_q;

    // A request needs a buffer place reserved up front
    assign accept_o      = head_valid_i && (credit_q != '0) && !redirect_i.valid;
    assign icache_req_o  = accept_o;
    assign icache_addr_o = {head_i.start_pc[`FE_ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};

    // Epoch flips in the redirect cycle itself, so the response due then is stale
    assign cur_epoch = epoch_q ^ redirect_i.valid;
    assign deliver   = infl_valid_q && icache_rsp_i.valid && (infl_epoch_q == cur_epoch);
    assign refund    = infl_valid_q && !deliver;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            epoch_q <= 1'b0;
        end else begin
            epoch_q <= cur_epoch;
        end
    end

    // Dropped responses give their reserved place back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_q <= CRD_W'(`FE_IB_CREDITS);
        end else begin
            credit_q <= credit_q - CRD_W'(accept_o) + CRD_W'(credit_return_i)
                        + CRD_W'(refund);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            infl_valid_q <= 1'b0;
        end else begin
            infl_valid_q <= accept_o;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_o) begin
            infl_blk_q   <= head_i;
            infl_epoch_q <= epoch_q;
        end
    end

    assign infl_ofs = infl_blk_q.start_pc[2 +: SLOT_W];
    assign infl_end = blk_len_t'(infl_ofs) + infl_blk_q.length;

    // Slots from the entry offset up to offset plus length
    always_comb begin
        for (int i = 0; i < `FE_FETCH_WIDTH; i++) begin
            slots_d[i].valid = (i >= int'(infl_ofs)) && (i < int'(infl_end));
            slots_d[i].pc    = {infl_blk_q.start_pc[`FE_ADDR_WIDTH-1:LINE_LSB],
                                slot_idx_t'(i), 2'b00};
            slots_d[i].instr = icache_rsp_i.line[i*32 +: 32];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bundle_valid_q <= 1'b0;
        end else begin
            bundle_valid_q <= deliver;
        end
    end

    always_ff @(posedge clk) begin
        if (deliver) begin
            slots_q <= slots_d;
        end
    end

    assign bundle_o.valid = bundle_valid_q;
    assign bundle_o.slots = slots_q;

endmodule

`default_nettype wire

//--- frontend.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module frontend (
    input  logic                         clk,
    input  logic                         rst_n,
    input  frontend_pkg::redirect_t      redirect_i,
    input  frontend_pkg::branch_update_t update_i,
    input  frontend_pkg::icache_rsp_t    icache_rsp_i,
    input  logic                         credit_return_i,
    output logic                         icache_req_o,
    output logic [`FE_ADDR_WIDTH-1:0]    icache_addr_o,
    output frontend_pkg::instr_bundle_t  bundle_o
);
    import frontend_pkg::*;

    fetch_block_t bpu_block;
    fetch_block_t ftq_head;
    logic         bpu_push;
    logic         ftq_full;
    logic         ftq_head_valid;
    logic         ifu_accept;

    // Prediction, one block per cycle
    bpu u_bpu (
        .clk       (clk),
        .rst_n     (rst_n),
        .redirect_i(redirect_i),
        .update_i  (update_i),
        .ftq_full_i(ftq_full),
        .push_o    (bpu_push),
        .block_o   (bpu_block)
    );

    ftq u_ftq (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect_i  (redirect_i),
        .push_i      (bpu_push),
        .block_i     (bpu_block),
        .full_o      (ftq_full),
        .head_valid_o(ftq_head_valid),
        .head_o      (ftq_head),
        .accept_i    (ifu_accept)
    );

    // Cache access and bundle output
    ifu u_ifu (
        .clk            (clk),
        .rst_n          (rst_n),
        .redirect_i     (redirect_i),
        .head_valid_i   (ftq_head_valid),
        .head_i         (ftq_head),
        .accept_o       (ifu_accept),
        .icache_req_o   (icache_req_o),
        .icache_addr_o  (icache_addr_o),
        .icache_rsp_i   (icache_rsp_i),
        .credit_return_i(credit_return_i),
        .bundle_o       (bundle_o)
    );

endmodule

`default_nettype wire

//--- frontend_props.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module frontend_props (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        icache_req_i,
    input logic [`FE_ADDR_WIDTH-1:0]   icache_addr_i,
    input frontend_pkg::instr_bundle_t bundle_i
);
    import frontend_pkg::*;

    localparam int SLOT_W   = $clog2(`FE_FETCH_WIDTH);
    localparam int LINE_LSB = 2 + SLOT_W;

    int unsigned                      fail_count;
    logic [`FE_FETCH_WIDTH-1:0]       slot_valid;
    logic [`FE_FETCH_WIDTH-1:0]       lowest_valid;
    logic [`FE_ADDR_WIDTH-1:LINE_LSB] req_line_q1;
    logic [`FE_ADDR_WIDTH-1:LINE_LSB] req_line_q2;
    logic                             pcs_in_line;

    initial fail_count = 0;

    // Line address of the request two cycles back
    always_ff @(posedge clk) begin
        req_line_q1 <= icache_addr_i[`FE_ADDR_WIDTH-1:LINE_LSB];
        req_line_q2 <= req_line_q1;
    end

    // Valid slot i sits at word i of the requested line
    always_comb begin
        pcs_in_line = 1'b1;
        for (int i = 0; i < `FE_FETCH_WIDTH; i++) begin
            slot_valid[i] = bundle_i.slots[i].valid;
            if (bundle_i.slots[i].valid &&
                (bundle_i.slots[i].pc != {req_line_q2, slot_idx_t'(i), 2'b00})) begin
                pcs_in_line = 1'b0;
            end
        end
    end

    assign lowest_valid = slot_valid & (~slot_valid + 1'b1);

    reset_quiet: assert property (@(posedge clk) !rst_n |=> !icache_req_i && !bundle_i.valid)
        else begin
            fail_count++;
            $error("request or bundle in the cycle after reset");
        end

    bundle_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        bundle_i.valid |-> slot_valid != '0)
        else begin
            fail_count++;
            $error("bundle without a valid slot");
        end

    // Valid slots form one run without holes
    slots_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        bundle_i.valid |-> ((slot_valid + lowest_valid) & slot_valid) == '0)
        else begin
            fail_count++;
            $error("slot valids %h not contiguous", slot_valid);
        end

    slot_pcs_in_line: assert property (@(posedge clk) disable iff (!rst_n)
        bundle_i.valid |-> pcs_in_line)
        else begin
            fail_count++;
            $error("slot PCs do not match the line requested two cycles before");
        end

    bundle_after_request: assert property (@(posedge clk) disable iff (!rst_n)
        bundle_i.valid |-> $past(icache_req_i, 2))
        else begin
            fail_count++;
            $error("bundle without a request two cycles before");
        end

endmodule

`default_nettype wire

//--- frontend_tb.sv
`timescale 1ns/100ps
`include "frontend_settings.svh"
`default_nettype none

module frontend_tb;
    import frontend_pkg::*;

    localparam logic [31:0] KEY      = 32'hA5A5_0000;
    localparam int          LIMIT    = 200;
    localparam int          RNG_SEED = 46622;
    localparam addr_t       BR_PC    = 32'h1C00_0108;
    localparam addr_t       BR_TGT   = 32'h1C00_0404;
    localparam addr_t       REDIR_PC = 32'h1C00_0208;

    logic           clk;
    logic           rst_n;
    redirect_t      redirect_i;
    branch_update_t update_i;
    icache_rsp_t    icache_rsp_i;
    logic           credit_return_i;
    logic           icache_req_o;
    addr_t          icache_addr_o;
    instr_bundle_t  bundle_o;

    logic  req_seen;
    addr_t addr_seen;
    logic  hold_credits;
    int    outstanding;
    int    err_count;
    int    tests_run;
    int    tests_failed;
    int    errs_at_start;
    addr_t exp_pc;

    frontend uut (.*);

    bind frontend frontend_props u_props (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache_req_i (icache_req_o),
        .icache_addr_i(icache_addr_o),
        .bundle_i     (bundle_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Cache: line comes back one cycle after the request
    always @(posedge clk) begin
        req_seen  <= rst_n && icache_req_o;
        addr_seen <= icache_addr_o;
    end

    initial begin
        icache_rsp_i = '0;
        forever begin
            @(negedge clk);
            icache_rsp_i.valid = req_seen;
            for (int i = 0; i < `FE_FETCH_WIDTH; i++) begin
                icache_rsp_i.line[i*32 +: 32] = (addr_seen + addr_t'(4 * i)) ^ KEY;
            end
        end
    end

    // Instruction buffer, gives places back after a random delay
    initial begin
        credit_return_i = 1'b0;
        outstanding     = 0;
        void'($urandom(RNG_SEED));
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                outstanding     = 0;
                credit_return_i = 1'b0;
            end else begin
                if (credit_return_i) begin
                    outstanding--;
                end
                if (bundle_o.valid) begin
                    outstanding++;
                end
                assert (outstanding <= `FE_IB_CREDITS) else begin
                    $display("buffer overrun, %0d bundles unreturned", outstanding);
                    err_count++;
                end
                credit_return_i = !hold_credits && (outstanding > 0) && ($urandom % 3 != 0);
            end
        end
    end

    function automatic int line_len(input addr_t pc);
        return `FE_FETCH_WIDTH - int'(pc[3:2]);
    endfunction

    function automatic addr_t next_line(input addr_t pc);
        return (pc & ~addr_t'(15)) + addr_t'(16);
    endfunction

    function automatic int total_errors();
        return err_count + int'(uut.u_props.fail_count);
    endfunction

    task automatic check_bundle(input instr_bundle_t b, input addr_t start, input int len);
        int    ofs;
        logic  exp_v;
        addr_t pc;
        ofs = int'(start[3:2]);
        for (int i = 0; i < `FE_FETCH_WIDTH; i++) begin
            exp_v = (i >= ofs) && (i < ofs + len);
            pc    = (start & ~addr_t'(15)) + addr_t'(4 * i);
            assert (b.slots[i].valid == exp_v) else begin
                $display("error bundle_o.slots[%0d].valid got %h expected %h",
                         i, b.slots[i].valid, exp_v);
                err_count++;
            end
            if (exp_v) begin
                assert (b.slots[i].pc == pc) else begin
                    $display("error bundle_o.slots[%0d].pc got %h expected %h",
                             i, b.slots[i].pc, pc);
                    err_count++;
                end
                assert (b.slots[i].instr == (pc ^ KEY)) else begin
                    $display("error bundle_o.slots[%0d].instr got %h expected %h",
                             i, b.slots[i].instr, pc ^ KEY);
                    err_count++;
                end
            end
        end
    endtask

    task automatic expect_bundle(input addr_t start, input int len);
        int n;
        n = 0;
        @(negedge clk);
        while (!bundle_o.valid && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (bundle_o.valid) begin
            check_bundle(bundle_o, start, len);
        end else begin
            $display("timed out waiting for the bundle at %h", start);
            err_count++;
        end
    endtask

    task automatic wait_request();
        int n;
        n = 0;
        @(negedge clk);
        while (!icache_req_o && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!icache_req_o) begin
            $display("timed out waiting for a cache request");
            err_count++;
        end
    endtask

    task automatic send_update(input addr_t pc, input logic taken, input addr_t target);
        @(negedge clk);
        update_i.valid  = 1'b1;
        update_i.pc     = pc;
        update_i.taken  = taken;
        update_i.target = target;
        @(negedge clk);
        update_i = '0;
    endtask

    task automatic do_redirect(input addr_t pc);
        @(negedge clk);
        redirect_i.valid = 1'b1;
        redirect_i.pc    = pc;
        @(negedge clk);
        redirect_i = '0;
        assert (!bundle_o.valid) else begin
            $display("a bundle from the old path came out after the redirect");
            err_count++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_errors() == errs_at_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     total_errors() - errs_at_start);
        end
        errs_at_start = total_errors();
    endtask

    initial begin
        rst_n         = 1'b0;
        redirect_i    = '0;
        update_i      = '0;
        hold_credits  = 1'b0;
        err_count     = 0;
        tests_run     = 0;
        tests_failed  = 0;
        errs_at_start = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        expect_bundle(`FE_RESET_PC, line_len(`FE_RESET_PC));
        exp_pc = next_line(`FE_RESET_PC);
        finish_test("reset start");

        repeat (6) begin
            expect_bundle(exp_pc, line_len(exp_pc));
            exp_pc = next_line(exp_pc);
        end
        finish_test("sequential fetch");

        @(posedge clk);
        hold_credits = 1'b1;
        for (int c = 0; c < 40; c++) begin
            @(negedge clk);
            if (bundle_o.valid) begin
                check_bundle(bundle_o, exp_pc, line_len(exp_pc));
                exp_pc = next_line(exp_pc);
            end
        end
        @(posedge clk);
        assert (outstanding == `FE_IB_CREDITS) else begin
            $display("error outstanding got %h expected %h", outstanding, `FE_IB_CREDITS);
            err_count++;
        end
        hold_credits = 1'b0;
        expect_bundle(exp_pc, line_len(exp_pc));
        finish_test("credit back-pressure");

        send_update(BR_PC, 1'b1, BR_TGT);
        send_update(BR_PC, 1'b1, BR_TGT);
        do_redirect(BR_PC & ~addr_t'(15));
        expect_bundle(BR_PC & ~addr_t'(15), int'(BR_PC[3:2]) + 1);
        expect_bundle(BR_TGT, line_len(BR_TGT));
        expect_bundle(next_line(BR_TGT), `FE_FETCH_WIDTH);
        finish_test("taken branch");

        send_update(BR_PC, 1'b0, BR_TGT);
        send_update(BR_PC, 1'b0, BR_TGT);
        do_redirect(BR_PC & ~addr_t'(15));
        expect_bundle(BR_PC & ~addr_t'(15), `FE_FETCH_WIDTH);
        expect_bundle(next_line(BR_PC), `FE_FETCH_WIDTH);
        finish_test("not-taken branch");

        // Response of this request is due in the redirect cycle
        wait_request();
        do_redirect(REDIR_PC);
        expect_bundle(REDIR_PC, line_len(REDIR_PC));
        expect_bundle(next_line(REDIR_PC), `FE_FETCH_WIDTH);
        expect_bundle(next_line(next_line(REDIR_PC)), `FE_FETCH_WIDTH);
        finish_test("redirect in flight");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- frontend.f
+incdir+.
frontend_pkg.sv
btb.sv
bimodal_pht.sv
bpu.sv
ftq.sv
ifu.sv
frontend.sv
frontend_props.sv
frontend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= frontend_tb
FILELIST  ?= frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
